// File: logic/sa_cfg.svh
`ifndef SA_CFG_SVH
`define SA_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// grid size
////////////////////////////////////////////////////////////////////////////

// rows of the PE grid
`define SA_ROW_NUM 4
// columns of the PE grid
`define SA_COL_NUM 4

////////////////////////////////////////////////////////////////////////////
// data widths
////////////////////////////////////////////////////////////////////////////

// extra accumulator bits above a single product
`define SA_HEADROOM 4
// 18 mode accumulator, 10 bit product plus headroom
`define SA_PIX18_W (10 + `SA_HEADROOM)
// output pixel, sized for the wider 8x8 product plus headroom
`define SA_PIX_W (16 + `SA_HEADROOM)
// readout row counter
`define SA_ROW_CNT_W ($clog2(`SA_ROW_NUM + 1))

`endif

// File: logic/sa_pkg.sv
`include "sa_cfg.svh"

package sa_pkg;

    // one unsigned pixel
    typedef logic [3:0] pixel4_t;

    // two pixels per row word
    // pixel 0 sits in the low nibble
    typedef logic [7:0] row_word_t;

    // one signed weight, low six bits of a lane
    typedef logic signed [5:0] weight6_t;

    // two weight lanes per column word
    // lane 0 sits in the low byte
    typedef logic [15:0] col_word_t;

    // wrapping accumulator
    typedef logic [`SA_PIX18_W-1:0] acc_t;

    // four accumulators per PE
    // index k is pixel k%2 times weight k/2
    typedef acc_t [3:0] pe_out_t;

    // zero extended output pixel
    typedef logic [`SA_PIX_W-1:0] out_pix_t;

    // readout half selector
    typedef enum logic [1:0] {RO_IDLE, RO_LOW, RO_HIGH} ro_state_t;

endpackage

// File: logic/sa_skew.sv
`timescale 1ns/1ps
`include "sa_cfg.svh"

module sa_skew import sa_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           en,
    input  row_word_t [`SA_ROW_NUM-1:0]    row_in,
    input  col_word_t [`SA_COL_NUM-1:0]    column_in,
    output row_word_t [`SA_ROW_NUM-1:0]    skewed_row,
    output col_word_t [`SA_COL_NUM-1:0]    skewed_col
);

    localparam int ROW_NUM = `SA_ROW_NUM;
    localparam int COL_NUM = `SA_COL_NUM;

    ////////////////////////////////////////////////////////////////////////////
    // row skew, row i lags by i strobes
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < ROW_NUM; i++) begin : g_row
        if (i == 0) begin : g_thru
            // row 0 enters the grid directly
            assign skewed_row[i] = row_in[i];
        end else begin : g_dly
            row_word_t [i-1:0] pipe;
            // shift only on a compute strobe
            always_ff @(posedge clk) begin
                if (reset) begin
                    pipe <= '0;
                end else if (en) begin
                    pipe[0] <= row_in[i];
                    for (int s = 1; s < i; s++) begin
                        pipe[s] <= pipe[s-1];
                    end
                end
            end
            assign skewed_row[i] = pipe[i-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // column skew, column j lags by j strobes
    ////////////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < COL_NUM; j++) begin : g_col
        if (j == 0) begin : g_thru
            assign skewed_col[j] = column_in[j];
        end else begin : g_dly
            col_word_t [j-1:0] pipe;
            always_ff @(posedge clk) begin
                if (reset) begin
                    pipe <= '0;
                end else if (en) begin
                    pipe[0] <= column_in[j];
                    for (int s = 1; s < j; s++) begin
                        pipe[s] <= pipe[s-1];
                    end
                end
            end
            // oldest stage feeds the top PE of this column
            assign skewed_col[j] = pipe[j-1];
        end
    end

endmodule

// File: logic/pe_18.sv
`timescale 1ns/1ps

module pe_18 import sa_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      en,
    input  row_word_t left,
    input  col_word_t up,
    output row_word_t right,
    output col_word_t bottom,
    output pe_out_t   out
);

    // unsigned 4 bit times signed 6 bit fits in 10 bits signed
    localparam int PROD_W = 10;
    localparam int ACC_W  = $bits(acc_t);

    pixel4_t                   pix [2];
    weight6_t                  wgt [2];
    logic signed [PROD_W-1:0]  prod [4];
    acc_t                      prod_ext [4];

    ////////////////////////////////////////////////////////////////////////////
    // operand unpacking
    ////////////////////////////////////////////////////////////////////////////

    assign pix[0] = left[3:0];
    assign pix[1] = left[7:4];
    // lanes are sign extended bytes, only the low six bits matter
    assign wgt[0] = up[5:0];
    assign wgt[1] = up[13:8];

    ////////////////////////////////////////////////////////////////////////////
    // four products
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            // pixel gets a zero sign bit before the signed multiply
            prod[k] = $signed({1'b0, pix[k % 2]}) * wgt[k / 2];
            // widen to accumulator, sign bit replicated
            prod_ext[k] = {{(ACC_W - PROD_W){prod[k][PROD_W-1]}}, prod[k]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pass-through and accumulate
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            right  <= '0;
            bottom <= '0;
            out    <= '0;
        end else if (en) begin
            // operands move one PE per strobe
            right  <= left;
            bottom <= up;
            // sums wrap at the accumulator width
            for (int k = 0; k < 4; k++) begin
                out[k] <= out[k] + prod_ext[k];
            end
        end
    end

    // no strobe, no change to any accumulator
    a_acc_hold : assert property (
        @(posedge clk) disable iff (reset)
        !en |=> $stable(out)
    );

endmodule

// File: logic/sa_array.sv
`timescale 1ns/1ps
`include "sa_cfg.svh"

module sa_array import sa_pkg::*; (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         en,
    input  row_word_t [`SA_ROW_NUM-1:0]                  row_in,
    input  col_word_t [`SA_COL_NUM-1:0]                  column_in,
    output pe_out_t   [`SA_ROW_NUM-1:0][`SA_COL_NUM-1:0] all_out
);

    localparam int ROW_NUM = `SA_ROW_NUM;
    localparam int COL_NUM = `SA_COL_NUM;

    // horizontal links, entry j feeds PE(i,j) from the left
    row_word_t h_bus [ROW_NUM][COL_NUM+1];
    // vertical links, entry i feeds PE(i,j) from above
    col_word_t v_bus [ROW_NUM+1][COL_NUM];

    ////////////////////////////////////////////////////////////////////////////
    // grid edges
    ////////////////////////////////////////////////////////////////////////////

    // left edge takes the skewed rows
    for (genvar i = 0; i < ROW_NUM; i++) begin : g_left
        assign h_bus[i][0] = row_in[i];
    end

    // top edge takes the skewed columns
    for (genvar j = 0; j < COL_NUM; j++) begin : g_top
        assign v_bus[0][j] = column_in[j];
    end

    ////////////////////////////////////////////////////////////////////////////
    // PE grid
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < ROW_NUM; i++) begin : g_row
        for (genvar j = 0; j < COL_NUM; j++) begin : g_col
            // right and bottom outputs feed the next neighbors
            // last column and last row outputs fall off the grid
            pe_18 u_pe (
                .clk    (clk),
                .reset  (reset),
                .en     (en),
                .left   (h_bus[i][j]),
                .up     (v_bus[i][j]),
                .right  (h_bus[i][j+1]),
                .bottom (v_bus[i+1][j]),
                .out    (all_out[i][j])
            );
        end
    end

endmodule

// File: logic/sa_readout.sv
`timescale 1ns/1ps
`include "sa_cfg.svh"

module sa_readout import sa_pkg::*; (
    input  logic                                         clk,
    input  logic                                         channel_out_reset,
    input  logic                                         channel_out_en,
    input  pe_out_t   [`SA_ROW_NUM-1:0][`SA_COL_NUM-1:0] all_out,
    output out_pix_t  [2*`SA_COL_NUM-1:0]                out,
    output logic                                         out_valid
);

    localparam int ROW_NUM = `SA_ROW_NUM;
    localparam int COL_NUM = `SA_COL_NUM;
    localparam int CNT_W   = `SA_ROW_CNT_W;

    typedef logic [CNT_W-1:0] row_cnt_t;

    ro_state_t                   state;
    ro_state_t                   state_nx;
    row_cnt_t                    row_cnt;
    row_cnt_t                    row_nx;
    out_pix_t [2*COL_NUM-1:0]    sel_out;
    int                          base;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    // order is row 0 low, row 0 high, row 1 low ... then back to idle
    always_comb begin
        state_nx = state;
        row_nx   = row_cnt;
        if (channel_out_en) begin
            case (state)
                RO_IDLE: begin
                    state_nx = RO_LOW;
                    row_nx   = '0;
                end
                RO_LOW: begin
                    state_nx = RO_HIGH;
                end
                RO_HIGH: begin
                    if (row_cnt == row_cnt_t'(ROW_NUM - 1)) begin
                        state_nx = RO_IDLE;
                        row_nx   = '0;
                    end else begin
                        state_nx = RO_LOW;
                        row_nx   = row_cnt + 1'b1;
                    end
                end
                default: begin
                    state_nx = RO_IDLE;
                    row_nx   = '0;
                end
            endcase
        end
    end

    // half select and zero extension
    // lower accumulator to slot 2j, higher to 2j+1
    always_comb begin
        sel_out = '0;
        base    = (state_nx == RO_HIGH) ? 2 : 0;
        if (state_nx != RO_IDLE) begin
            for (int j = 0; j < COL_NUM; j++) begin
                sel_out[2*j]   = out_pix_t'(all_out[row_nx][j][base]);
                sel_out[2*j+1] = out_pix_t'(all_out[row_nx][j][base+1]);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registered output
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            state     <= RO_IDLE;
            row_cnt   <= '0;
            out       <= '0;
            out_valid <= 1'b0;
        end else begin
            state     <= state_nx;
            row_cnt   <= row_nx;
            // valid pulse only for a strobe that lands on a half
            out_valid <= channel_out_en && (state_nx != RO_IDLE);
            // snapshot held until the next strobe
            if (channel_out_en) begin
                out <= sel_out;
            end
        end
    end

    // sequencer and output register agree on idle
    a_idle_zero : assert property (
        @(posedge clk) disable iff (channel_out_reset)
        (state == RO_IDLE) |-> (out == '0)
    );

    // strobes come at most every other cycle
    a_valid_pulse : assert property (
        @(posedge clk) disable iff (channel_out_reset)
        out_valid |=> !out_valid
    );

endmodule

// File: logic/sa_18.sv
`timescale 1ns/1ps
`include "sa_cfg.svh"

module sa_18 import sa_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           en,
    input  logic                           channel_out_reset,
    input  logic                           channel_out_en,
    input  row_word_t [`SA_ROW_NUM-1:0]    row_in,
    input  col_word_t [`SA_COL_NUM-1:0]    column_in,
    output out_pix_t  [2*`SA_COL_NUM-1:0]  out,
    output logic                           out_valid
);

    // skewed operands into the grid
    row_word_t [`SA_ROW_NUM-1:0]                  skewed_row;
    col_word_t [`SA_COL_NUM-1:0]                  skewed_col;
    // every PE's four accumulators
    pe_out_t   [`SA_ROW_NUM-1:0][`SA_COL_NUM-1:0] all_out;

    ////////////////////////////////////////////////////////////////////////////
    // skew, grid, readout
    ////////////////////////////////////////////////////////////////////////////

    sa_skew u_skew (
        .clk        (clk),
        .reset      (reset),
        .en         (en),
        .row_in     (row_in),
        .column_in  (column_in),
        .skewed_row (skewed_row),
        .skewed_col (skewed_col)
    );

    sa_array u_array (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .row_in    (skewed_row),
        .column_in (skewed_col),
        .all_out   (all_out)
    );

    // readout has its own reset domain
    sa_readout u_readout (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .all_out           (all_out),
        .out               (out),
        .out_valid         (out_valid)
    );

endmodule

// File: sim/tb_sa_18.sv
`timescale 1ns/1ps
`include "sa_cfg.svh"

module tb_sa_18 import sa_pkg::*; ();

    localparam int ROW_NUM       = `SA_ROW_NUM;
    localparam int COL_NUM       = `SA_COL_NUM;
    localparam int ACC_W         = `SA_PIX18_W;
    localparam int DRAIN_STEPS   = ROW_NUM + COL_NUM - 2;
    localparam int VALID_TIMEOUT = 8;

    typedef row_word_t [ROW_NUM-1:0] row_vec_t;
    typedef col_word_t [COL_NUM-1:0] col_vec_t;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       en;
    logic                       channel_out_reset;
    logic                       channel_out_en;
    row_vec_t                   row_in;
    col_vec_t                   column_in;
    out_pix_t [2*COL_NUM-1:0]   out;
    logic                       out_valid;

    int seed = 32'h3cc6b8e4;

    // data steps entered since the last reset, zero drain steps left out
    row_vec_t hist_row [$];
    col_vec_t hist_col [$];

    always #5 clk = ~clk;

    sa_18 dut (
        .clk               (clk),
        .reset             (reset),
        .en                (en),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .row_in            (row_in),
        .column_in         (column_in),
        .out               (out),
        .out_valid         (out_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            stop_on_failure("value mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // sign extended weight byte for one lane
    function automatic logic [7:0] lane_byte(input weight6_t w);
        return {{2{w[5]}}, w};
    endfunction

    function automatic col_word_t make_col(input weight6_t w0, input weight6_t w1);
        return {lane_byte(w1), lane_byte(w0)};
    endfunction

    // accumulator k is pixel k%2 times weight k/2, summed over all data steps
    function automatic acc_t expected_acc(input int r, input int c, input int k);
        row_word_t rw;
        col_word_t cw;
        pixel4_t   pv;
        weight6_t  wv;
        int        sum;
        sum = 0;
        for (int s = 0; s < hist_row.size(); s++) begin
            rw = hist_row[s][r];
            cw = hist_col[s][c];
            pv = (k % 2 == 0) ? rw[3:0] : rw[7:4];
            // low six bits of the lane carry the weight
            wv = (k / 2 == 0) ? cw[5:0] : cw[13:8];
            sum += int'(pv) * int'(wv);
        end
        // wraps like the hardware accumulator
        return acc_t'(sum);
    endfunction

    function automatic row_vec_t rand_rows();
        row_vec_t v;
        for (int i = 0; i < ROW_NUM; i++) begin
            v[i] = row_word_t'($random(seed));
        end
        return v;
    endfunction

    function automatic col_vec_t rand_cols();
        col_vec_t v;
        for (int j = 0; j < COL_NUM; j++) begin
            v[j] = make_col(weight6_t'($random(seed)), weight6_t'($random(seed)));
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus, all driven right after a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        @(negedge clk);
        reset             = 1'b1;
        channel_out_reset = 1'b1;
        en                = 1'b0;
        channel_out_en    = 1'b0;
        row_in            = '0;
        column_in         = '0;
        repeat (4) @(negedge clk);
        reset             = 1'b0;
        channel_out_reset = 1'b0;
        hist_row.delete();
        hist_col.delete();
    endtask

    // one compute strobe
    task automatic push_step(input row_vec_t rows, input col_vec_t cols, input bit record);
        row_in    = rows;
        column_in = cols;
        en        = 1'b1;
        if (record) begin
            hist_row.push_back(rows);
            hist_col.push_back(cols);
        end
        @(negedge clk);
        en        = 1'b0;
        row_in    = '0;
        column_in = '0;
    endtask

    // zeros flush the skew so every PE sees its last data step
    task automatic drain();
        for (int s = 0; s < DRAIN_STEPS; s++) begin
            push_step('0, '0, 1'b0);
        end
    endtask

    // junk on the operand ports with en low
    task automatic idle_with_noise(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            row_in    = rand_rows();
            column_in = rand_cols();
            @(negedge clk);
        end
        row_in    = '0;
        column_in = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // readout
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_out_zero(input string where);
        for (int s = 0; s < 2 * COL_NUM; s++) begin
            check_eq($sformatf("%s out[%0d]", where, s), 32'(out[s]), 0);
        end
        check_eq($sformatf("%s out_valid", where), 32'(out_valid), 0);
    endtask

    // lower accumulator of the half in slot 2j, higher one in 2j+1
    task automatic check_half(input int r, input int h);
        int s;
        for (int j = 0; j < COL_NUM; j++) begin
            for (int m = 0; m < 2; m++) begin
                s = 2 * j + m;
                check_eq($sformatf("out[%0d] row %0d half %0d", s, r, h),
                         32'(out[s]), 32'(expected_acc(r, j, 2 * h + m)));
                // zero extension above the accumulator
                check_eq($sformatf("out[%0d] upper bits", s), 32'(out[s] >> ACC_W), 0);
            end
        end
    endtask

    // one strobe, wait for the valid pulse, check it lasts one cycle
    task automatic read_half(input int r, input int h);
        int waited;
        channel_out_en = 1'b1;
        @(negedge clk);
        channel_out_en = 1'b0;
        waited = 0;
        while (!out_valid && waited < VALID_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            stop_on_failure("out_valid never came after a readout strobe");
        end
        check_eq("out_valid latency", 32'(waited), 0);
        check_half(r, h);
        // gap cycle, out holds and valid drops
        @(negedge clk);
        check_eq("out_valid after pulse", 32'(out_valid), 0);
        check_half(r, h);
    endtask

    task automatic read_grid();
        for (int r = 0; r < ROW_NUM; r++) begin
            read_half(r, 0);
            read_half(r, 1);
        end
        // extra strobe goes back to idle
        channel_out_en = 1'b1;
        @(negedge clk);
        channel_out_en = 1'b0;
        check_out_zero("after last half");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        apply_reset();
        for (int n = 0; n < 3; n++) begin
            check_out_zero("after reset");
            @(negedge clk);
        end
    endtask

    task automatic test_single_step();
        row_vec_t rows;
        col_vec_t cols;
        apply_reset();
        for (int i = 0; i < ROW_NUM; i++) begin
            rows[i] = {pixel4_t'(15 - i), pixel4_t'(i + 1)};
        end
        // lane 0 goes negative on the first columns
        for (int j = 0; j < COL_NUM; j++) begin
            cols[j] = make_col(weight6_t'(j - 2), weight6_t'(31 - 7 * j));
        end
        push_step(rows, cols, 1'b1);
        drain();
        read_grid();
    endtask

    task automatic test_random_run();
        apply_reset();
        for (int s = 0; s < 20; s++) begin
            push_step(rand_rows(), rand_cols(), 1'b1);
        end
        drain();
        read_grid();
    endtask

    // 40 times 465 overflows 14 bits
    task automatic test_wrap();
        row_vec_t rows;
        col_vec_t cols;
        apply_reset();
        for (int i = 0; i < ROW_NUM; i++) begin
            rows[i] = 8'hff;
        end
        for (int j = 0; j < COL_NUM; j++) begin
            cols[j] = make_col(weight6_t'(31), weight6_t'(31));
        end
        for (int s = 0; s < 40; s++) begin
            push_step(rows, cols, 1'b1);
        end
        drain();
        read_grid();
    endtask

    task automatic test_readout_restart();
        apply_reset();
        for (int s = 0; s < 3; s++) begin
            push_step(rand_rows(), rand_cols(), 1'b1);
        end
        drain();
        read_half(0, 0);
        read_half(0, 1);
        read_half(1, 0);
        // readout reset only, accumulators stay
        channel_out_reset = 1'b1;
        @(negedge clk);
        channel_out_reset = 1'b0;
        check_out_zero("after readout reset");
        read_grid();
    endtask

    task automatic test_en_gaps();
        apply_reset();
        for (int s = 0; s < 6; s++) begin
            push_step(rand_rows(), rand_cols(), 1'b1);
            idle_with_noise(1 + s % 3);
        end
        drain();
        read_grid();
    endtask

    initial begin
        reset             = 1'b1;
        channel_out_reset = 1'b1;
        en                = 1'b0;
        channel_out_en    = 1'b0;
        row_in            = '0;
        column_in         = '0;
        test_reset_state();
        test_single_step();
        test_random_run();
        test_wrap();
        test_readout_restart();
        test_en_gaps();
        $display("Test OK");
        $finish;
    end

endmodule

// File: sources.f
+incdir+logic
logic/sa_pkg.sv
logic/sa_skew.sv
logic/pe_18.sv
logic/sa_array.sv
logic/sa_readout.sv
logic/sa_18.sv
sim/tb_sa_18.sv

// File: Makefile
# simulator and options
VERILATOR  = verilator
FLAGS      = --binary --assert --Mdir obj_dir
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_sa_18
FILELIST   = sources.f
PASS_MSG   = Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
